//--- list.f
+incdir+tests
logic/issue_pkg.sv
logic/regfile.sv
logic/fu_status_table.sv
logic/issue_select.sv
logic/issue_stage.sv
tests/issue_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module issue_tb -f list.f -Mdir obj_dir -o issue_sim
./obj_dir/issue_sim > sim.log
cat sim.log

if grep -q "Test passed" sim.log; then
    exit 0
fi
exit 1

//--- tests/issue_ref.svh
// issue stage reference model for the testbench
// shadow register file, expected issue word and LFSR random source
`ifndef ISSUE_REF_SVH
`define ISSUE_REF_SVH

typedef struct packed {
    fu_t     fu;
    regsel_t rd;
    regsel_t rs1;
    regsel_t rs2;
    word_t   imm;
    logic    i_type;
    tag_t    t1;
    tag_t    t2;
} instr_t;

typedef struct packed {
    fu_t     fu;
    regsel_t rd;
    word_t   rdat1;
    word_t   rdat2;
    word_t   imm;
} issue_t;

word_t       shadow [32];
logic [15:0] lfsr_state = 16'd454;

// register 0 is hardwired to zero
function automatic void shadow_write(input regsel_t r, input word_t d);
    if (r != '0) begin
        shadow[r] = d;
    end
endfunction

// operands are read at issue time, so this follows the last writeback before the issue
function automatic issue_t expected_issue(input instr_t ins);
    issue_t e;
    e.fu    = ins.fu;
    e.rd    = ins.rd;
    e.imm   = ins.imm;
    e.rdat1 = (ins.rs1 == '0) ? '0 : shadow[ins.rs1];
    e.rdat2 = ins.i_type ? ins.imm : ((ins.rs2 == '0) ? '0 : shadow[ins.rs2]);
    return e;
endfunction

// 16-bit Galois LFSR, taps 16 14 13 11, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
        b          = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        v = {v[30:0], b};
    end
    return v;
endfunction

// nonzero register number
function automatic regsel_t rand_reg();
    regsel_t r;
    r = '0;
    while (r == '0) begin
        r = regsel_t'(lfsr_bits(5));
    end
    return r;
endfunction

`endif

//--- tests/issue_tb.sv
// testbench for the issue stage
// acts as dispatcher, execute units and writeback, and checks every issued word
`timescale 1ns/100ps

module issue_tb import issue_pkg::*; ();

    logic              CLK = 1'b0;
    logic              nRST;
    logic              disp_valid;
    fu_t               disp_fu;
    regsel_t           disp_rd;
    regsel_t           disp_rs1;
    regsel_t           disp_rs2;
    word_t             disp_imm;
    logic              disp_i_type;
    tag_t              disp_t1;
    tag_t              disp_t2;
    logic              wb_valid;
    fu_t               wb_fu;
    regsel_t           wb_reg;
    word_t             wb_data;
    logic              freeze;
    logic              branch_miss;
    logic              issue_valid;
    fu_t               issue_fu;
    regsel_t           issue_rd;
    word_t             issue_rdat1;
    word_t             issue_rdat2;
    word_t             issue_imm;
    logic [NUM_FU-1:0] fu_busy;

    `include "issue_ref.svh"

    // tag meaning the operand waits on the ALU slot
    localparam tag_t TAG_ALU = 2'd1;

    issue_t exp_q [$];
    issue_t exp_head;
    int     error_count = 0;
    int     check_count = 0;
    int     cyc = 0;
    int     last_issue_cyc = 0;
    int     prev_issue_cyc = 0;
    logic   frozen_edge = 1'b0;

    issue_stage #(.DATA_W(32), .REG_N(32)) uut (.*);

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cyc         <= cyc + 1;
        frozen_edge <= freeze;
    end

    // a new issue is issue_valid high after an edge that was not frozen
    initial begin
        forever begin
            @(negedge CLK);
            if ((nRST === 1'b1) && issue_valid && !frozen_edge) begin
                prev_issue_cyc = last_issue_cyc;
                last_issue_cyc = cyc;
                if (exp_q.size() == 0) begin
                    $display("unexpected issue from slot %0d at %0t", issue_fu, $time);
                    error_count++;
                end else begin
                    exp_head = exp_q.pop_front();
                    check("issue_fu", 32'(issue_fu), 32'(exp_head.fu));
                    check("issue_rd", 32'(issue_rd), 32'(exp_head.rd));
                    check("issue_rdat1", issue_rdat1, exp_head.rdat1);
                    check("issue_rdat2", issue_rdat2, exp_head.rdat2);
                    check("issue_imm", issue_imm, exp_head.imm);
                end
            end
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic dispatch(input instr_t ins);
        step();
        disp_valid  = 1'b1;
        disp_fu     = ins.fu;
        disp_rd     = ins.rd;
        disp_rs1    = ins.rs1;
        disp_rs2    = ins.rs2;
        disp_imm    = ins.imm;
        disp_i_type = ins.i_type;
        disp_t1     = ins.t1;
        disp_t2     = ins.t2;
        step();
        disp_valid = 1'b0;
    endtask

    task automatic writeback(input fu_t fu, input regsel_t r, input word_t d);
        step();
        wb_valid = 1'b1;
        wb_fu    = fu;
        wb_reg   = r;
        wb_data  = d;
        shadow_write(r, d);
        step();
        wb_valid = 1'b0;
    endtask

    // execute result is random data for the instruction's rd
    task automatic finish_exec(input instr_t ins);
        writeback(ins.fu, ins.rd, lfsr_bits(32));
    endtask

    task automatic wait_drained(input string what);
        for (int t = 0; (t < 40) && (exp_q.size() != 0); t++) begin
            @(posedge CLK);
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t: %s did not issue", $time, what);
            error_count++;
            exp_q.delete();
        end
    endtask

    task automatic issue_now(input instr_t ins, input string what);
        exp_q.push_back(expected_issue(ins));
        dispatch(ins);
        wait_drained(what);
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %0d errors", num, name, error_count - err_before);
    endtask

    function automatic instr_t random_instr(input fu_t fu, input tag_t t1);
        instr_t ins;
        ins.fu     = fu;
        ins.rd     = rand_reg();
        ins.rs1    = rand_reg();
        ins.rs2    = rand_reg();
        ins.imm    = lfsr_bits(32);
        ins.i_type = 1'b0;
        ins.t1     = t1;
        ins.t2     = TAG_NONE;
        return ins;
    endfunction

    initial begin
        instr_t  a;
        instr_t  b;
        instr_t  c;
        issue_t  snap;
        regsel_t last_reg;
        int      err0;

        nRST        = 1'b0;
        disp_valid  = 1'b0;
        disp_fu     = FU_ALU;
        disp_rd     = '0;
        disp_rs1    = '0;
        disp_rs2    = '0;
        disp_imm    = '0;
        disp_i_type = 1'b0;
        disp_t1     = TAG_NONE;
        disp_t2     = TAG_NONE;
        wb_valid    = 1'b0;
        wb_fu       = FU_ALU;
        wb_reg      = '0;
        wb_data     = '0;
        freeze      = 1'b0;
        branch_miss = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        err0 = error_count;
        check("fu_busy after reset", 32'(fu_busy), 32'd0);
        check("issue_valid after reset", 32'(issue_valid), 32'd0);
        last_reg = '0;
        repeat (8) begin
            last_reg = rand_reg();
            writeback(FU_ALU, last_reg, lfsr_bits(32));
        end
        // register 0 drops this write
        writeback(FU_ALU, '0, lfsr_bits(32));
        a = random_instr(FU_ALU, TAG_NONE);
        a.rs1 = last_reg;
        a.rs2 = '0;
        issue_now(a, "untagged alu");
        finish_exec(a);
        end_test(1, "reset and register file", err0);

        err0 = error_count;
        a = random_instr(FU_ALU, TAG_NONE);
        a.i_type = 1'b1;
        issue_now(a, "immediate alu");
        check("issue_rdat2 carries imm", issue_rdat2, a.imm);
        finish_exec(a);
        end_test(2, "immediate", err0);

        err0 = error_count;
        a = random_instr(FU_ALU, TAG_NONE);
        issue_now(a, "producer alu");
        b = random_instr(FU_LDST, TAG_ALU);
        b.rs1 = a.rd;
        dispatch(b);
        // nothing is queued, so an early issue shows up as unexpected
        repeat (5) step();
        check("ldst slot busy", 32'(fu_busy[FU_LDST]), 32'd1);
        finish_exec(a);
        exp_q.push_back(expected_issue(b));
        wait_drained("woken ldst");
        finish_exec(b);
        end_test(3, "tag wakeup", err0);

        err0 = error_count;
        a = random_instr(FU_ALU, TAG_NONE);
        issue_now(a, "producer alu");
        b = random_instr(FU_BR, TAG_ALU);
        c = random_instr(FU_LDST, TAG_ALU);
        b.rs1 = a.rd;
        c.rs1 = a.rd;
        dispatch(b);
        dispatch(c);
        finish_exec(a);
        exp_q.push_back(expected_issue(b));
        exp_q.push_back(expected_issue(c));
        wait_drained("branch and ldst");
        check("ldst issue one cycle after branch", last_issue_cyc - prev_issue_cyc, 1);
        finish_exec(b);
        finish_exec(c);
        end_test(4, "oldest first", err0);

        err0 = error_count;
        a = random_instr(FU_ALU, TAG_NONE);
        exp_q.push_back(expected_issue(a));
        snap = expected_issue(a);
        dispatch(a);
        // the ALU issues on this edge and freeze then holds its word
        step();
        freeze = 1'b1;
        b = random_instr(FU_BR, TAG_NONE);
        dispatch(b);
        repeat (4) begin
            step();
            check("issue_valid held", 32'(issue_valid), 32'd1);
            check("issue_fu held", 32'(issue_fu), 32'(FU_ALU));
            check("issue_rdat1 held", issue_rdat1, snap.rdat1);
        end
        check("branch slot busy", 32'(fu_busy[FU_BR]), 32'd1);
        exp_q.push_back(expected_issue(b));
        freeze = 1'b0;
        wait_drained("branch after freeze");
        finish_exec(a);
        finish_exec(b);
        end_test(5, "freeze", err0);

        err0 = error_count;
        a = random_instr(FU_ALU, TAG_NONE);
        issue_now(a, "producer alu");
        b = random_instr(FU_LDST, TAG_ALU);
        c = random_instr(FU_BR, TAG_NONE);
        c.t2 = TAG_ALU;
        dispatch(b);
        dispatch(c);
        step();
        branch_miss = 1'b1;
        step();
        branch_miss = 1'b0;
        check("only alu busy after flush", 32'(fu_busy), 32'd1);
        finish_exec(a);
        repeat (6) step();
        check("all slots idle", 32'(fu_busy), 32'd0);
        b = random_instr(FU_LDST, TAG_NONE);
        c = random_instr(FU_BR, TAG_NONE);
        issue_now(b, "fresh ldst");
        issue_now(c, "fresh branch");
        finish_exec(b);
        finish_exec(c);
        check("all slots idle at end", 32'(fu_busy), 32'd0);
        end_test(6, "flush", err0);

        $display("tests: 6, checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- logic/issue_stage.sv
// issue stage top, joins status table, select and register file
// reads operands for the granted slot and registers the issue word
`timescale 1ns/100ps

module issue_stage import issue_pkg::*; #(
    parameter int DATA_W = 32,
    parameter int REG_N  = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              disp_valid,
    input  fu_t               disp_fu,
    input  regsel_t           disp_rd,
    input  regsel_t           disp_rs1,
    input  regsel_t           disp_rs2,
    input  word_t             disp_imm,
    input  logic              disp_i_type,
    input  tag_t              disp_t1,
    input  tag_t              disp_t2,
    input  logic              wb_valid,
    input  fu_t               wb_fu,
    input  regsel_t           wb_reg,
    input  word_t             wb_data,
    input  logic              freeze,
    input  logic              branch_miss,
    output logic              issue_valid,
    output fu_t               issue_fu,
    output regsel_t           issue_rd,
    output word_t             issue_rdat1,
    output word_t             issue_rdat2,
    output word_t             issue_imm,
    output logic [NUM_FU-1:0] fu_busy
);

    regsel_t [NUM_FU-1:0] row_rd;
    regsel_t [NUM_FU-1:0] row_rs1;
    regsel_t [NUM_FU-1:0] row_rs2;
    word_t   [NUM_FU-1:0] row_imm;
    logic    [NUM_FU-1:0] row_i_type;
    logic    [NUM_FU-1:0] rdy_ops;
    logic    [NUM_FU-1:0] issue_grant;
    logic    [NUM_FU-1:0] slot_clear;

    fu_t     sel_fu;
    regsel_t sel_rd;
    regsel_t sel_rs1;
    regsel_t sel_rs2;
    word_t   sel_imm;
    logic    sel_i_type;
    word_t   rf_rdat1;
    word_t   rf_rdat2;

    fu_status_table u_table (
        .CLK(CLK), .nRST(nRST),
        .disp_valid(disp_valid), .disp_fu(disp_fu), .disp_rd(disp_rd),
        .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_imm(disp_imm),
        .disp_i_type(disp_i_type), .disp_t1(disp_t1), .disp_t2(disp_t2),
        .wb_valid(wb_valid), .wb_fu(wb_fu), .slot_clear(slot_clear),
        .row_rd(row_rd), .row_rs1(row_rs1), .row_rs2(row_rs2),
        .row_imm(row_imm), .row_i_type(row_i_type), .rdy_ops(rdy_ops)
    );

    issue_select u_select (
        .CLK(CLK), .nRST(nRST),
        .disp_valid(disp_valid), .disp_fu(disp_fu),
        .wb_valid(wb_valid), .wb_fu(wb_fu),
        .freeze(freeze), .branch_miss(branch_miss), .rdy_ops(rdy_ops),
        .issue_grant(issue_grant), .slot_clear(slot_clear), .fu_busy(fu_busy)
    );

    regfile #(.DATA_W(DATA_W), .REG_N(REG_N)) u_regfile (
        .CLK(CLK), .nRST(nRST),
        .wen(wb_valid), .wsel(wb_reg), .wdata(wb_data),
        .rsel1(sel_rs1), .rsel2(sel_rs2),
        .rdat1(rf_rdat1), .rdat2(rf_rdat2)
    );

    // grant is one-hot, so the last match is the only match
    always_comb begin
        sel_fu     = FU_ALU;
        sel_rd     = '0;
        sel_rs1    = '0;
        sel_rs2    = '0;
        sel_imm    = '0;
        sel_i_type = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (issue_grant[i]) begin
                sel_fu     = fu_t'(i);
                sel_rd     = row_rd[i];
                sel_rs1    = row_rs1[i];
                sel_rs2    = row_rs2[i];
                sel_imm    = row_imm[i];
                sel_i_type = row_i_type[i];
            end
        end
    end

    // valid holds under freeze, drops when nothing was granted
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else if (!freeze) begin
            issue_valid <= |issue_grant;
        end
    end

    // no grant can happen while frozen, so the word holds by itself
    always_ff @(posedge CLK) begin
        if (|issue_grant) begin
            issue_fu    <= sel_fu;
            issue_rd    <= sel_rd;
            issue_rdat1 <= rf_rdat1;
            issue_rdat2 <= sel_i_type ? sel_imm : rf_rdat2;
            issue_imm   <= sel_imm;
        end
    end

endmodule

//--- logic/issue_select.sv
// issue select, runs the per-slot state machines and slot ages
// grants the oldest ready slot, at most one per cycle
`timescale 1ns/100ps

module issue_select import issue_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              disp_valid,
    input  fu_t               disp_fu,
    input  logic              wb_valid,
    input  fu_t               wb_fu,
    input  logic              freeze,
    input  logic              branch_miss,
    input  logic [NUM_FU-1:0] rdy_ops,
    output logic [NUM_FU-1:0] issue_grant,
    output logic [NUM_FU-1:0] slot_clear,
    output logic [NUM_FU-1:0] fu_busy
);

    slot_state_e state   [NUM_FU];
    slot_state_e state_n [NUM_FU];
    age_t        age     [NUM_FU];
    age_t        age_n   [NUM_FU];
    logic [NUM_FU-1:0] eligible;
    logic [NUM_FU-1:0] pick;
    logic [NUM_FU-1:0] pending;
    logic        found;
    age_t        best_age;

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            // a waiting slot whose tags just cleared can go this cycle
            eligible[i] = (state[i] == SLOT_RDY) || ((state[i] == SLOT_WAIT) && rdy_ops[i]);
            pending[i]  = (state[i] == SLOT_WAIT) || (state[i] == SLOT_RDY);
            slot_clear[i] = branch_miss && pending[i];
            fu_busy[i]    = (state[i] != SLOT_EMPTY);
        end
    end

    // oldest first, strict compare keeps the lowest index on a tie
    always_comb begin
        pick     = '0;
        found    = 1'b0;
        best_age = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (eligible[i] && (!found || (age[i] > best_age))) begin
                pick     = '0;
                pick[i]  = 1'b1;
                found    = 1'b1;
                best_age = age[i];
            end
        end
        issue_grant = (freeze || branch_miss) ? '0 : pick;
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            state_n[i] = state[i];
            case (state[i])
                SLOT_EMPTY: begin
                    if (disp_valid && (disp_fu == fu_t'(i))) begin
                        state_n[i] = SLOT_WAIT;
                    end
                end
                SLOT_WAIT: begin
                    if (branch_miss) begin
                        state_n[i] = SLOT_EMPTY;
                    end else if (issue_grant[i]) begin
                        state_n[i] = SLOT_EX;
                    end else if (rdy_ops[i]) begin
                        state_n[i] = SLOT_RDY;
                    end
                end
                SLOT_RDY: begin
                    if (branch_miss) begin
                        state_n[i] = SLOT_EMPTY;
                    end else if (issue_grant[i]) begin
                        state_n[i] = SLOT_EX;
                    end
                end
                SLOT_EX: begin
                    if (wb_valid && (wb_fu == fu_t'(i))) begin
                        state_n[i] = SLOT_EMPTY;
                    end
                end
                default: state_n[i] = SLOT_EMPTY;
            endcase
        end
    end

    // every dispatch makes the other in-flight slots one step older
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            age_n[i] = age[i];
            if (disp_valid && (disp_fu == fu_t'(i))) begin
                age_n[i] = '0;
            end else if (disp_valid && pending[i] && (age[i] != AGE_MAX)) begin
                age_n[i] = age[i] + 2'd1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                state[i] <= SLOT_EMPTY;
                age[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                state[i] <= state_n[i];
                age[i]   <= age_n[i];
            end
        end
    end

endmodule

//--- logic/fu_status_table.sv
// function-unit status table, one row per slot
// holds instruction fields and operand tags, tags clear on writeback
`timescale 1ns/100ps

module fu_status_table import issue_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    disp_valid,
    input  fu_t                     disp_fu,
    input  regsel_t                 disp_rd,
    input  regsel_t                 disp_rs1,
    input  regsel_t                 disp_rs2,
    input  word_t                   disp_imm,
    input  logic                    disp_i_type,
    input  tag_t                    disp_t1,
    input  tag_t                    disp_t2,
    input  logic                    wb_valid,
    input  fu_t                     wb_fu,
    input  logic [NUM_FU-1:0]       slot_clear,
    output regsel_t [NUM_FU-1:0]    row_rd,
    output regsel_t [NUM_FU-1:0]    row_rs1,
    output regsel_t [NUM_FU-1:0]    row_rs2,
    output word_t   [NUM_FU-1:0]    row_imm,
    output logic    [NUM_FU-1:0]    row_i_type,
    output logic    [NUM_FU-1:0]    rdy_ops
);

    tag_t [NUM_FU-1:0] t1;
    tag_t [NUM_FU-1:0] t2;
    tag_t              wb_tag;
    logic [NUM_FU-1:0] disp_hit;

    // tag value that names the unit writing back this cycle
    assign wb_tag = tag_t'(wb_fu) + 2'd1;

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            disp_hit[i] = disp_valid && (disp_fu == fu_t'(i));
        end
    end

    // instruction fields
    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_FU; i++) begin
            if (disp_hit[i]) begin
                row_rd[i]     <= disp_rd;
                row_rs1[i]    <= disp_rs1;
                row_rs2[i]    <= disp_rs2;
                row_imm[i]    <= disp_imm;
                row_i_type[i] <= disp_i_type;
            end
        end
    end

    // operand tags
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            t1 <= '0;
            t2 <= '0;
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (disp_hit[i]) begin
                    // a producer finishing this very cycle is already satisfied
                    t1[i] <= (wb_valid && (disp_t1 == wb_tag)) ? TAG_NONE : disp_t1;
                    t2[i] <= (wb_valid && (disp_t2 == wb_tag)) ? TAG_NONE : disp_t2;
                end else if (slot_clear[i]) begin
                    t1[i] <= TAG_NONE;
                    t2[i] <= TAG_NONE;
                end else if (wb_valid) begin
                    if (t1[i] == wb_tag) begin
                        t1[i] <= TAG_NONE;
                    end
                    if (t2[i] == wb_tag) begin
                        t2[i] <= TAG_NONE;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            rdy_ops[i] = (t1[i] == TAG_NONE) && (t2[i] == TAG_NONE);
        end
    end

endmodule

//--- logic/regfile.sv
// scalar register file, two read ports and one write port
// register 0 reads as zero and a same-cycle write is forwarded to the reads
`timescale 1ns/100ps

module regfile import issue_pkg::*; #(
    parameter int DATA_W = 32,
    parameter int REG_N  = 32
) (
    input  logic    CLK,
    input  logic    nRST,
    input  logic    wen,
    input  regsel_t wsel,
    input  word_t   wdata,
    input  regsel_t rsel1,
    input  regsel_t rsel2,
    output word_t   rdat1,
    output word_t   rdat2
);

    logic [DATA_W-1:0] regs [REG_N];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    // write-through so an issue in the writeback cycle sees the new value
    always_comb begin
        rdat1 = (rsel1 == '0) ? '0 : ((wen && (wsel == rsel1)) ? wdata : regs[rsel1]);
        rdat2 = (rsel2 == '0) ? '0 : ((wen && (wsel == rsel2)) ? wdata : regs[rsel2]);
    end

endmodule

//--- logic/issue_pkg.sv
// issue stage shared definitions
// widths, slot encoding and the per-slot state enum
package issue_pkg;

    // data word and register index
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regsel_t;

    // function-unit slot index
    typedef logic [1:0] fu_t;

    localparam fu_t FU_ALU  = 2'd0;
    localparam fu_t FU_LDST = 2'd1;
    localparam fu_t FU_BR   = 2'd2;

    // number of slots, tied to the 2-bit slot and tag encodings
    localparam int NUM_FU = 3;

    // producer tag
    // 0 means the operand is available, k means waiting on slot k-1
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_NONE = 2'd0;

    // saturating age count, larger is older
    typedef logic [1:0] age_t;

    localparam age_t AGE_MAX = 2'd3;

    // slot lifecycle
    typedef enum logic [1:0] {
        SLOT_EMPTY = 2'd0,
        SLOT_WAIT  = 2'd1,
        SLOT_RDY   = 2'd2,
        SLOT_EX    = 2'd3
    } slot_state_e;

endpackage
